// ==== include/riscv_settings.svh ====
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// Datapath and address width
`define RISCV_XLEN 32

// Architectural register count, x0 included
`define RISCV_REG_COUNT 32

// Fetch starts here after reset
`define RISCV_INITIAL_PC 32'h0040_0000

// PC step between sequential instructions
`define RISCV_INSTR_BYTES 4

`endif

// ==== rtl/riscv_pkg.sv ====
`default_nettype none

`include "riscv_settings.svh"

package riscv_pkg;

    typedef logic [`RISCV_XLEN-1:0] word_t;
    typedef logic [4:0]             reg_addr_t;
    typedef logic [3:0]             alu_op_t;
    typedef logic [2:0]             funct3_t;
    typedef logic [6:0]             opcode_t;

    // Major opcodes
    localparam opcode_t OPCODE_R      = 7'b0110011;
    localparam opcode_t OPCODE_I      = 7'b0010011;
    localparam opcode_t OPCODE_LOAD   = 7'b0000011;
    localparam opcode_t OPCODE_STORE  = 7'b0100011;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_LUI    = 7'b0110111;

    // funct3 for ALU ops; SUB and SRA are told apart by instruction bit 30
    localparam funct3_t FUNCT3_ADD = 3'b000;
    localparam funct3_t FUNCT3_SLL = 3'b001;
    localparam funct3_t FUNCT3_SLT = 3'b010;
    localparam funct3_t FUNCT3_XOR = 3'b100;
    localparam funct3_t FUNCT3_SR  = 3'b101;
    localparam funct3_t FUNCT3_OR  = 3'b110;
    localparam funct3_t FUNCT3_AND = 3'b111;
    localparam funct3_t FUNCT3_BEQ = 3'b000;
    localparam funct3_t FUNCT3_BNE = 3'b001;

    // ALU operation codes
    localparam alu_op_t ALU_AND = 4'b0000;
    localparam alu_op_t ALU_OR  = 4'b0001;
    localparam alu_op_t ALU_ADD = 4'b0010;
    localparam alu_op_t ALU_SUB = 4'b0110;
    localparam alu_op_t ALU_SLT = 4'b0111;
    localparam alu_op_t ALU_SRL = 4'b1000;
    localparam alu_op_t ALU_SLL = 4'b1001;
    localparam alu_op_t ALU_SRA = 4'b1010;
    localparam alu_op_t ALU_XOR = 4'b1101;

endpackage

`default_nettype wire

// ==== rtl/id_ex_if.sv ====
`default_nettype none

interface id_ex_if;
    import riscv_pkg::*;

    word_t     pc;
    alu_op_t   alu_op;
    logic      alu_src;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    logic      mem_to_reg;
    logic      branch;
    logic      branch_ne;
    word_t     imm;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;

    modport decode (output pc, alu_op, alu_src, mem_read, mem_write, reg_write,
                    mem_to_reg, branch, branch_ne, imm, rs1, rs2, rd);

    modport execute (input pc, alu_op, alu_src, mem_read, mem_write, reg_write,
                     mem_to_reg, branch, branch_ne, imm, rs1, rs2, rd);

endinterface

`default_nettype wire

// ==== rtl/register_file.sv ====
`default_nettype none

`include "riscv_settings.svh"

module register_file (
    input  logic                 clk,
    input  riscv_pkg::reg_addr_t rs1,
    input  riscv_pkg::reg_addr_t rs2,
    input  riscv_pkg::reg_addr_t wb_rd,
    input  logic                 wb_reg_write,
    input  riscv_pkg::word_t     wb_data,
    output riscv_pkg::word_t     rs1_data,
    output riscv_pkg::word_t     rs2_data
);
    import riscv_pkg::*;

    word_t regs [0:`RISCV_REG_COUNT-1];

    // x0 is hardwired; a same-edge write passes straight through
    function automatic word_t read_port(reg_addr_t addr);
        word_t value;
        if (addr == '0)
            value = '0;
        else if (wb_reg_write && (wb_rd == addr))
            value = wb_data;
        else
            value = regs[addr];
        return value;
    endfunction

    always_ff @(posedge clk)
    begin
        if (wb_reg_write && (wb_rd != '0))
            regs[wb_rd] <= wb_data;
    end

    // Registered reads line up with the instruction entering execute
    always_ff @(posedge clk)
    begin
        rs1_data <= read_port(rs1);
        rs2_data <= read_port(rs2);
    end

endmodule

`default_nettype wire

// ==== rtl/instruction_decode.sv ====
`default_nettype none

module instruction_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  riscv_pkg::word_t     instruction,
    input  riscv_pkg::word_t     id_pc,
    input  logic                 branch_taken,
    input  logic                 branch_flush_late,
    output riscv_pkg::reg_addr_t rs1,
    output riscv_pkg::reg_addr_t rs2,
    output logic                 load_use_stall,
    id_ex_if.decode              ex
);
    import riscv_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    funct7_alt;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    alu_op_t dec_alu_op;
    logic    dec_alu_src;
    logic    dec_mem_read;
    logic    dec_mem_write;
    logic    dec_reg_write;
    logic    dec_mem_to_reg;
    logic    dec_branch;
    logic    dec_branch_ne;
    word_t   dec_imm;
    logic    bubble;

    // Bit 30 picks SUB/SRA, but only R-type uses it for ADD
    function automatic alu_op_t alu_for(funct3_t f3, logic alt, logic is_reg);
        alu_op_t op;
        case (f3)
            FUNCT3_ADD: op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
            FUNCT3_SLL: op = ALU_SLL;
            FUNCT3_SLT: op = ALU_SLT;
            FUNCT3_XOR: op = ALU_XOR;
            FUNCT3_SR:  op = alt ? ALU_SRA : ALU_SRL;
            FUNCT3_OR:  op = ALU_OR;
            FUNCT3_AND: op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode     = instruction[6:0];
    assign funct3     = instruction[14:12];
    assign funct7_alt = instruction[30];

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                    instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};

    // LUI adds its immediate to x0
    assign rs1 = (opcode == OPCODE_LUI) ? '0 : instruction[19:15];
    assign rs2 = instruction[24:20];

    always_comb
    begin
        dec_alu_op     = ALU_ADD;
        dec_alu_src    = 1'b0;
        dec_mem_read   = 1'b0;
        dec_mem_write  = 1'b0;
        dec_reg_write  = 1'b0;
        dec_mem_to_reg = 1'b0;
        dec_branch     = 1'b0;
        dec_branch_ne  = 1'b0;
        dec_imm        = '0;
        case (opcode)
            OPCODE_R:
            begin
                dec_reg_write = 1'b1;
                dec_alu_op    = alu_for(funct3, funct7_alt, 1'b1);
            end
            OPCODE_I:
            begin
                dec_reg_write = 1'b1;
                dec_alu_src   = 1'b1;
                dec_imm       = imm_i;
                dec_alu_op    = alu_for(funct3, funct7_alt, 1'b0);
            end
            OPCODE_LOAD:
            begin
                dec_reg_write  = 1'b1;
                dec_alu_src    = 1'b1;
                dec_mem_read   = 1'b1;
                dec_mem_to_reg = 1'b1;
                dec_imm        = imm_i;
            end
            OPCODE_STORE:
            begin
                dec_alu_src   = 1'b1;
                dec_mem_write = 1'b1;
                dec_imm       = imm_s;
            end
            OPCODE_BRANCH:
            begin
                // Only BEQ/BNE; compare by subtraction
                dec_alu_op    = ALU_SUB;
                dec_branch    = (funct3 == FUNCT3_BEQ) || (funct3 == FUNCT3_BNE);
                dec_branch_ne = (funct3 == FUNCT3_BNE);
                dec_imm       = imm_b;
            end
            OPCODE_LUI:
            begin
                dec_reg_write = 1'b1;
                dec_alu_src   = 1'b1;
                dec_imm       = imm_u;
            end
            default:
            begin
                dec_imm = '0;
            end
        endcase
    end

    // Load in execute feeding this instruction, unless a branch redirects
    assign load_use_stall = ex.mem_read && (ex.rd != '0) && !branch_taken &&
                            ((ex.rd == rs1) || (ex.rd == rs2));

    assign bubble = rst || load_use_stall || branch_taken || branch_flush_late;

    //////////////////////////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (bubble)
        begin
            ex.mem_read   <= 1'b0;
            ex.mem_write  <= 1'b0;
            ex.reg_write  <= 1'b0;
            ex.mem_to_reg <= 1'b0;
            ex.branch     <= 1'b0;
            ex.branch_ne  <= 1'b0;
        end
        else
        begin
            ex.mem_read   <= dec_mem_read;
            ex.mem_write  <= dec_mem_write;
            ex.reg_write  <= dec_reg_write;
            ex.mem_to_reg <= dec_mem_to_reg;
            ex.branch     <= dec_branch;
            ex.branch_ne  <= dec_branch_ne;
        end
    end

    // Payload follows decode every cycle
    always_ff @(posedge clk)
    begin
        ex.pc      <= id_pc;
        ex.alu_op  <= dec_alu_op;
        ex.alu_src <= dec_alu_src;
        ex.imm     <= dec_imm;
        ex.rs1     <= rs1;
        ex.rs2     <= rs2;
        ex.rd      <= instruction[11:7];
    end

endmodule

`default_nettype wire

// ==== rtl/execute_pipeline.sv ====
`default_nettype none

module execute_pipeline (
    input  logic                 clk,
    input  logic                 rst,
    id_ex_if.execute             ex,
    input  riscv_pkg::word_t     rs1_data,
    input  riscv_pkg::word_t     rs2_data,
    input  riscv_pkg::word_t     d_read_data,
    output logic                 branch_taken,
    output logic                 branch_flush_late,
    output riscv_pkg::word_t     branch_target,
    output riscv_pkg::word_t     d_address,
    output riscv_pkg::word_t     d_write_data,
    output logic                 mem_read,
    output logic                 mem_write,
    output riscv_pkg::reg_addr_t wb_rd,
    output logic                 wb_reg_write,
    output riscv_pkg::word_t     wb_data
);
    import riscv_pkg::*;

    // Execute stage
    word_t     op_a;
    word_t     op_b;
    word_t     rs2_fwd;
    word_t     alu_result;
    logic      alu_zero;

    // Memory stage
    word_t     m_alu_result;
    word_t     m_store_data;
    reg_addr_t m_rd;
    logic      m_zero;
    logic      m_reg_write;
    logic      m_mem_to_reg;
    logic      m_branch;
    logic      m_branch_ne;

    // Writeback stage
    word_t     w_alu_result;
    logic      w_mem_to_reg;

    // Nearest producer wins; x0 never forwards
    function automatic word_t forward(reg_addr_t src, word_t rf_data);
        word_t value;
        if (src == '0)
            value = '0;
        else if (m_reg_write && (m_rd == src))
            value = m_alu_result;
        else if (wb_reg_write && (wb_rd == src))
            value = wb_data;
        else
            value = rf_data;
        return value;
    endfunction

    always_comb
    begin
        op_a    = forward(ex.rs1, rs1_data);
        rs2_fwd = forward(ex.rs2, rs2_data);
        op_b    = ex.alu_src ? ex.imm : rs2_fwd;
    end

    always_comb
    begin
        case (ex.alu_op)
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_SLT: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLL: alu_result = op_a << op_b[4:0];
            ALU_SRL: alu_result = op_a >> op_b[4:0];
            ALU_SRA: alu_result = $signed(op_a) >>> op_b[4:0];
            default: alu_result = op_a + op_b;
        endcase
    end

    assign alu_zero = (alu_result == '0);

    //////////////////////////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst || branch_taken)
        begin
            mem_read     <= 1'b0;
            mem_write    <= 1'b0;
            m_reg_write  <= 1'b0;
            m_mem_to_reg <= 1'b0;
            m_branch     <= 1'b0;
            m_branch_ne  <= 1'b0;
        end
        else
        begin
            mem_read     <= ex.mem_read;
            mem_write    <= ex.mem_write;
            m_reg_write  <= ex.reg_write;
            m_mem_to_reg <= ex.mem_to_reg;
            m_branch     <= ex.branch;
            m_branch_ne  <= ex.branch_ne;
        end
    end

    always_ff @(posedge clk)
    begin
        m_alu_result  <= alu_result;
        m_store_data  <= rs2_fwd;
        m_rd          <= ex.rd;
        m_zero        <= alu_zero;
        branch_target <= ex.pc + ex.imm;
    end

    // BEQ on equal, BNE on not equal
    assign branch_taken = m_branch && (m_branch_ne ? !m_zero : m_zero);

    assign d_address    = m_alu_result;
    assign d_write_data = m_store_data;

    //////////////////////////////////////////////////////////////////////
    // MEM/WB register
    //////////////////////////////////////////////////////////////////////

    // Late flush covers the instruction fetched the cycle of the branch
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_reg_write      <= 1'b0;
            w_mem_to_reg      <= 1'b0;
            branch_flush_late <= 1'b0;
        end
        else
        begin
            wb_reg_write      <= m_reg_write;
            w_mem_to_reg      <= m_mem_to_reg;
            branch_flush_late <= branch_taken;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_rd        <= m_rd;
        w_alu_result <= m_alu_result;
    end

    // Load data arrives from the registered data memory read
    assign wb_data = w_mem_to_reg ? d_read_data : w_alu_result;

endmodule

`default_nettype wire

// ==== rtl/riscv_pipeline.sv ====
`default_nettype none

`include "riscv_settings.svh"

module riscv_pipeline (
    input  logic             clk,
    input  logic             rst,
    input  riscv_pkg::word_t instruction,
    input  riscv_pkg::word_t d_read_data,
    output riscv_pkg::word_t pc,
    output logic             imem_read,
    output riscv_pkg::word_t d_address,
    output riscv_pkg::word_t d_write_data,
    output logic             mem_read,
    output logic             mem_write,
    output riscv_pkg::word_t write_back_data
);
    import riscv_pkg::*;

    word_t     id_pc;
    word_t     branch_target;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     wb_data;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t wb_rd;
    logic      wb_reg_write;
    logic      load_use_stall;
    logic      branch_taken;
    logic      branch_flush_late;
    logic      fetch_warmup;
    logic      decode_rst;

    id_ex_if id_ex ();

    ////////////////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= `RISCV_INITIAL_PC;
        else if (branch_taken)
            pc <= branch_target;
        else if (!load_use_stall)
            pc <= pc + `RISCV_INSTR_BYTES;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            id_pc <= `RISCV_INITIAL_PC;
        else if (!load_use_stall)
            id_pc <= pc;
    end

    // The word fetched during reset is fetched again, so decode drops it once
    always_ff @(posedge clk)
    begin
        if (rst)
            fetch_warmup <= 1'b1;
        else
            fetch_warmup <= 1'b0;
    end

    assign decode_rst      = rst || fetch_warmup;
    assign imem_read       = !load_use_stall;
    assign write_back_data = wb_data;

    instruction_decode u_decode (
        .clk               (clk),
        .rst               (decode_rst),
        .instruction       (instruction),
        .id_pc             (id_pc),
        .branch_taken      (branch_taken),
        .branch_flush_late (branch_flush_late),
        .rs1               (rs1),
        .rs2               (rs2),
        .load_use_stall    (load_use_stall),
        .ex                (id_ex.decode)
    );

    register_file u_regs (
        .clk          (clk),
        .rs1          (rs1),
        .rs2          (rs2),
        .wb_rd        (wb_rd),
        .wb_reg_write (wb_reg_write),
        .wb_data      (wb_data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    execute_pipeline u_execute (
        .clk               (clk),
        .rst               (rst),
        .ex                (id_ex.execute),
        .rs1_data          (rs1_data),
        .rs2_data          (rs2_data),
        .d_read_data       (d_read_data),
        .branch_taken      (branch_taken),
        .branch_flush_late (branch_flush_late),
        .branch_target     (branch_target),
        .d_address         (d_address),
        .d_write_data      (d_write_data),
        .mem_read          (mem_read),
        .mem_write         (mem_write),
        .wb_rd             (wb_rd),
        .wb_reg_write      (wb_reg_write),
        .wb_data           (wb_data)
    );

endmodule

`default_nettype wire

// ==== testbench/riscv_props.sv ====
`default_nettype none

`include "riscv_settings.svh"

module riscv_props (
    input logic             clk,
    input logic             rst,
    input riscv_pkg::word_t pc,
    input logic             imem_read,
    input logic             mem_read,
    input logic             mem_write
);
    timeunit 1ns;
    timeprecision 100ps;

    // Failed property count, polled by the testbench
    int unsigned violations = 0;

    //////////////////////////////////////////////////////////////////////
    // Reset and fetch
    //////////////////////////////////////////////////////////////////////

    // Registers settle at the first reset edge and hold one cycle beyond
    reset_state: assert property (@(posedge clk)
        rst |=> (pc == `RISCV_INITIAL_PC) && imem_read && !mem_read && !mem_write)
    else
    begin
        $error("reset state wrong at pc 0x%08h", pc);
        violations++;
    end

    stall_holds_pc: assert property (@(posedge clk) disable iff (rst)
        !imem_read |=> $stable(pc))
    else
    begin
        $error("pc moved during a load-use stall");
        violations++;
    end

    // A bubble in execute cannot cause a second stall
    stall_single_cycle: assert property (@(posedge clk) disable iff (rst)
        !imem_read |=> imem_read)
    else
    begin
        $error("imem_read low for two cycles in a row");
        violations++;
    end

    pc_step: assert property (@(posedge clk) disable iff (rst)
        !$stable(pc) |-> (pc == $past(pc) + `RISCV_INSTR_BYTES) || (pc[1:0] == 2'b00))
    else
    begin
        $error("pc changed to 0x%08h", pc);
        violations++;
    end

    //////////////////////////////////////////////////////////////////////
    // Data memory strobes
    //////////////////////////////////////////////////////////////////////

    mem_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write))
    else
    begin
        $error("mem_read and mem_write high together");
        violations++;
    end

endmodule

`default_nettype wire

// ==== testbench/riscv_tb.sv ====
`default_nettype none

`include "riscv_settings.svh"

module riscv_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import riscv_pkg::*;

    localparam int    MAX_CYCLES   = 400;
    localparam int    DRAIN_CYCLES = 12;
    localparam word_t NOP          = 32'h0000_0013;

    logic  clk;
    logic  rst = 1'b1;
    word_t instruction = NOP;
    word_t d_read_data = '0;
    word_t pc;
    logic  imem_read;
    word_t d_address;
    word_t d_write_data;
    logic  mem_read;
    logic  mem_write;
    word_t write_back_data;

    word_t      rom [0:63];
    word_t      ram [0:63];
    logic [5:0] rom_len = '0;
    word_t      rom_offset;
    word_t      exp_addr [$];
    word_t      exp_data [$];
    int         store_count = 0;
    logic       wb_check_due = 1'b0;
    word_t      wb_expected = '0;

    riscv_pipeline DUT (
        .clk             (clk),
        .rst             (rst),
        .instruction     (instruction),
        .d_read_data     (d_read_data),
        .pc              (pc),
        .imem_read       (imem_read),
        .d_address       (d_address),
        .d_write_data    (d_write_data),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .write_back_data (write_back_data)
    );

    bind riscv_pipeline riscv_props u_props (
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .imem_read (imem_read),
        .mem_read  (mem_read),
        .mem_write (mem_write)
    );

    //////////////////////////////////////////////////////////////////////
    // Instruction encoders
    //////////////////////////////////////////////////////////////////////

    function automatic word_t op_reg(int funct7, int funct3, int rd, int rs1, int rs2);
        return {7'(funct7), 5'(rs2), 5'(rs1), 3'(funct3), 5'(rd), 7'b0110011};
    endfunction

    function automatic word_t op_imm(int funct3, int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'(funct3), 5'(rd), 7'b0010011};
    endfunction

    function automatic word_t load_word(int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic word_t store_word(int rs2, int rs1, int offset);
        word_t imm;
        imm = offset;
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch(int funct3, int rs1, int rs2, int offset);
        word_t imm;
        imm = offset;
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(funct3), imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic word_t load_upper(int rd, int imm20);
        return {20'(imm20), 5'(rd), 7'b0110111};
    endfunction

    // Preload contents mix the word index into both halves
    function automatic word_t ram_fill(logic [5:0] index);
        return 32'h5a00_0000 ^ {10'b0, index, 10'b0, index};
    endfunction

    task automatic emit(word_t word);
        rom[rom_len] = word;
        rom_len = rom_len + 6'd1;
    endtask

    task automatic expect_store(word_t addr, word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic load_program();
        // Dependent ALU chain at MEM and WB distance
        emit(op_imm(0, 1, 0, 5));             // x1 = 5
        emit(op_imm(0, 2, 1, 7));             // x2 = x1 + 7 = 12
        emit(op_reg(0, 0, 3, 2, 1));          // x3 = x2 + x1 = 17
        emit(op_reg(7'h20, 0, 4, 3, 2));      // x4 = x3 - x2 = 5
        emit(store_word(4, 0, 'h40));
        emit(store_word(3, 0, 'h44));
        emit(op_imm(0, 5, 0, 'hf0));          // x5 = 0xf0
        emit(op_imm(0, 6, 0, 'hcc));          // x6 = 0xcc
        emit(op_reg(0, 7, 7, 5, 6));          // and
        emit(op_reg(0, 6, 8, 5, 6));          // or
        emit(op_reg(0, 4, 9, 5, 6));          // xor
        emit(store_word(7, 0, 'h48));
        emit(store_word(8, 0, 'h4c));
        emit(store_word(9, 0, 'h50));
        emit(op_imm(0, 10, 0, -8));           // x10 = -8
        emit(op_reg(0, 2, 11, 10, 1));        // slt -8 < 5
        emit(op_reg(0, 2, 12, 1, 10));        // slt 5 < -8
        emit(store_word(11, 0, 'h54));
        emit(store_word(12, 0, 'h58));
        emit(op_imm(0, 13, 0, 4));            // x13 = 4
        emit(op_reg(0, 1, 14, 1, 13));        // sll
        emit(op_reg(0, 5, 15, 10, 13));       // srl of a negative value
        emit(op_reg(7'h20, 5, 16, 10, 13));   // sra of a negative value
        emit(store_word(14, 0, 'h5c));
        emit(store_word(15, 0, 'h60));
        emit(store_word(16, 0, 'h64));
        emit(load_upper(17, 'h12345));
        emit(op_imm(0, 18, 17, 'h678));
        emit(store_word(18, 0, 'h68));
        // Load followed at once by its consumer
        emit(load_word(19, 0, 'h14));
        emit(op_reg(0, 0, 20, 19, 1));
        emit(store_word(20, 0, 'h6c));
        // Untaken BEQ then untaken BNE
        emit(branch(0, 1, 2, 16));
        emit(store_word(1, 0, 'h70));
        emit(branch(1, 1, 4, 16));
        emit(store_word(2, 0, 'h74));
        // Taken BEQ skips three instructions
        emit(branch(0, 1, 4, 16));
        emit(store_word(3, 0, 'h78));
        emit(store_word(3, 0, 'h7c));
        emit(op_imm(0, 1, 0, 99));
        emit(store_word(6, 0, 'h78));
        // Taken BNE skips three instructions
        emit(branch(1, 1, 2, 16));
        emit(store_word(1, 0, 'h7c));
        emit(store_word(1, 0, 'h80));
        emit(op_imm(0, 2, 0, 1));
        emit(store_word(2, 0, 'h7c));
        emit(store_word(1, 0, 'h80));
        emit(branch(0, 0, 0, 0));
        emit(NOP);
        emit(NOP);
        emit(NOP);
    endtask

    task automatic load_expected();
        expect_store(32'h40, 32'd5);
        expect_store(32'h44, 32'd17);
        expect_store(32'h48, 32'h0000_00c0);
        expect_store(32'h4c, 32'h0000_00fc);
        expect_store(32'h50, 32'h0000_003c);
        expect_store(32'h54, 32'd1);
        expect_store(32'h58, 32'd0);
        expect_store(32'h5c, 32'h0000_0050);
        expect_store(32'h60, 32'h0fff_ffff);
        expect_store(32'h64, 32'hffff_ffff);
        expect_store(32'h68, 32'h1234_5678);
        expect_store(32'h6c, 32'h5a05_000a);
        expect_store(32'h70, 32'd5);
        expect_store(32'h74, 32'd12);
        expect_store(32'h78, 32'h0000_00cc);
        expect_store(32'h7c, 32'd12);
        expect_store(32'h80, 32'd5);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure(string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic report_store_mismatch(word_t addr, word_t data);
        if (addr != exp_addr[store_count])
            $display("FAIL time %0t d_address expected 0x%08h got 0x%08h",
                     $time, exp_addr[store_count], addr);
        if (data != exp_data[store_count])
            $display("FAIL time %0t d_write_data expected 0x%08h got 0x%08h",
                     $time, exp_data[store_count], data);
        stop_with_failure($sformatf("store number %0d did not match", store_count));
    endtask

    task automatic check_store(word_t addr, word_t data);
        if (store_count >= exp_addr.size())
            stop_with_failure("a store appeared after the last expected one");
        else
        begin
            store_matches: assert ((addr == exp_addr[store_count]) &&
                                   (data == exp_data[store_count]))
                store_count <= store_count + 1;
            else
                report_store_mismatch(addr, data);
        end
    endtask

    always @(posedge clk)
    begin
        if (DUT.u_props.violations != 0)
            stop_with_failure("a protocol assertion on the DUT failed");
    end

    //////////////////////////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////////////////////////

    assign rom_offset = pc - `RISCV_INITIAL_PC;

    always @(posedge clk)
    begin
        if (imem_read)
            instruction <= rom[rom_offset[7:2]];
    end

    always @(posedge clk)
    begin
        if (mem_read)
            d_read_data <= ram[d_address[7:2]];
        if (mem_write)
        begin
            ram[d_address[7:2]] <= d_write_data;
            check_store(d_address, d_write_data);
        end
    end

    // The loaded word must come back on write_back_data in writeback
    always @(posedge clk)
    begin
        wb_check_due <= mem_read;
        if (mem_read)
            wb_expected <= ram[d_address[7:2]];
        if (wb_check_due)
        begin
            writeback_matches: assert (write_back_data == wb_expected)
            else
            begin
                $display("FAIL time %0t write_back_data expected 0x%08h got 0x%08h",
                         $time, wb_expected, write_back_data);
                stop_with_failure("loaded word did not reach writeback");
            end
        end
    end

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    initial
    begin
        int cycles;
        for (int i = 0; i < 64; i++)
            ram[6'(i)] <= ram_fill(6'(i));
        load_program();
        load_expected();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while ((store_count < exp_addr.size()) && (cycles < MAX_CYCLES))
        begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (store_count < exp_addr.size())
            stop_with_failure("timeout waiting for the final store");
        else
        begin
            // A stray store during the drain still trips the check
            repeat (DRAIN_CYCLES) @(posedge clk);
            @(negedge clk);
            if (DUT.u_props.violations != 0)
                stop_with_failure("a protocol assertion on the DUT failed");
            else
            begin
                $display("TB PASSED");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
rtl/riscv_pkg.sv
rtl/id_ex_if.sv
rtl/register_file.sv
rtl/instruction_decode.sv
rtl/execute_pipeline.sv
rtl/riscv_pipeline.sv
testbench/riscv_props.sv
testbench/riscv_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module riscv_tb -f filelist.f -o riscv_sim
	./obj_dir/riscv_sim +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
